/* rom_pkg.sv */
package rom_pkg;

// SDRAM geometry
localparam int SDRAM_AW  = 22;    // Word address width
localparam int NUM_SLOTS = 3;

// Region start of each consumer, in 16-bit words
localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = 22'h000000;
localparam logic [SDRAM_AW-1:0] SND_OFFSET  = 22'h040000;
localparam logic [SDRAM_AW-1:0] GFX_OFFSET  = 22'h080000;

// Lower value wins arbitration
typedef enum logic [1:0] {
    SLOT_GFX  = 2'd0,
    SLOT_SND  = 2'd1,
    SLOT_MAIN = 2'd2
} slot_e;

typedef enum logic [1:0] {
    ARB_IDLE = 2'd0,
    ARB_REQ  = 2'd1,    // sdram_req high, waiting for ack
    ARB_WAIT = 2'd2     // Acked, waiting for data_rdy
} arb_state_e;

// Slot to arbiter
typedef struct packed {
    logic                pending;
    logic [SDRAM_AW-1:0] addr;    // Relative to the slot region
} slot_req_t;

// Arbiter to all slots, each one filters on the tag
typedef struct packed {
    logic        fill;
    slot_e       slot;
    logic [15:0] data;
} slot_rsp_t;

endpackage

/* rom_slot.sv */
module rom_slot #(
    parameter int AW = 18,
    parameter int DW = 16     // 8 or 16
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cs,
    input  logic [AW-1:0]      addr,
    output logic               ok,
    output logic [DW-1:0]      data,
    input  rom_pkg::slot_e     my_slot,
    output rom_pkg::slot_req_t req,
    input  rom_pkg::slot_rsp_t rsp
);

logic [rom_pkg::SDRAM_AW-1:0] word_addr;   // Consumer address in words
logic [rom_pkg::SDRAM_AW-1:0] tag;         // Word address of the cached data
logic [15:0]                  cache_data;
logic                         valid;
logic                         pending;
logic                         fill_mine;
logic                         start_miss;

if (DW == 8) begin : g_byte
    assign word_addr = {{(rom_pkg::SDRAM_AW - AW + 1){1'b0}}, addr[AW-1:1]};
    // Bytes were swapped on download, even address sits in the upper half
    assign data = addr[0] ? cache_data[7:0] : cache_data[15:8];
end else begin : g_word
    assign word_addr = {{(rom_pkg::SDRAM_AW - AW){1'b0}}, addr};
    assign data = cache_data;
end

assign ok         = cs && valid && (tag == word_addr);
assign fill_mine  = rsp.fill && (rsp.slot == my_slot);
assign start_miss = cs && !ok && !pending;

assign req = '{pending: pending, addr: tag};

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        valid   <= 1'b0;
        pending <= 1'b0;
    end else if (fill_mine) begin
        valid   <= 1'b1;
        pending <= 1'b0;
    end else if (start_miss) begin
        valid   <= 1'b0;    // Old word gets replaced
        pending <= 1'b1;
    end
end

// Tag doubles as the request address while pending
always_ff @(posedge clk) begin
    if (start_miss) begin
        tag <= word_addr;
    end
    if (fill_mine) begin
        cache_data <= rsp.data;
    end
end

endmodule

/* rom_arbiter.sv */
module rom_arbiter (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         downloading,
    input  rom_pkg::slot_req_t           reqs [rom_pkg::NUM_SLOTS],
    output rom_pkg::slot_rsp_t           rsp,
    output logic                         sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0] sdram_addr,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    input  logic [15:0]                  data_read
);

rom_pkg::arb_state_e          state;
rom_pkg::slot_e               grant;        // Slot being served
rom_pkg::slot_e               pick;
logic                         any_pending;
logic                         start;
logic [rom_pkg::SDRAM_AW-1:0] pick_offset;

// Scan from the top so the lowest pending index is kept
always_comb begin
    any_pending = 1'b0;
    pick        = rom_pkg::SLOT_GFX;
    for (int i = rom_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
        if (reqs[i].pending) begin
            any_pending = 1'b1;
            pick        = rom_pkg::slot_e'(i);
        end
    end
end

always_comb begin
    case (pick)
        rom_pkg::SLOT_GFX: pick_offset = rom_pkg::GFX_OFFSET;
        rom_pkg::SLOT_SND: pick_offset = rom_pkg::SND_OFFSET;
        default:           pick_offset = rom_pkg::MAIN_OFFSET;
    endcase
end

// Download owns the SDRAM, hold everything back
assign start = (state == rom_pkg::ARB_IDLE) && !downloading && any_pending;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state     <= rom_pkg::ARB_IDLE;
        sdram_req <= 1'b0;
    end else begin
        case (state)
            rom_pkg::ARB_IDLE: begin
                if (start) begin
                    sdram_req <= 1'b1;
                    state     <= rom_pkg::ARB_REQ;
                end
            end
            rom_pkg::ARB_REQ: begin
                if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= rom_pkg::ARB_WAIT;
                end
            end
            rom_pkg::ARB_WAIT: begin
                if (data_rdy) begin
                    state <= rom_pkg::ARB_IDLE;
                end
            end
            default: state <= rom_pkg::ARB_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (start) begin
        grant      <= pick;
        sdram_addr <= pick_offset + reqs[pick].addr;   // Absolute word address
    end
end

// Fill goes to every slot, only the granted one takes it
assign rsp = '{
    fill: (state == rom_pkg::ARB_WAIT) && data_rdy,
    slot: grant,
    data: data_read
};

endmodule

/* rom_dwnld.sv */
module rom_dwnld (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         downloading,
    input  logic [24:0]                  ioctl_addr,
    input  logic [7:0]                   ioctl_dout,
    input  logic                         ioctl_wr,
    input  logic                         sdram_ack,
    output logic [rom_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,    // Active low
    output logic                         prog_we
);

logic byte_wr;

assign byte_wr = downloading && ioctl_wr;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        prog_we <= 1'b0;
    end else if (byte_wr) begin
        prog_we <= 1'b1;
    end else if (sdram_ack) begin
        prog_we <= 1'b0;     // Write taken by the SDRAM
    end
end

always_ff @(posedge clk) begin
    if (byte_wr) begin
        prog_addr <= ioctl_addr[rom_pkg::SDRAM_AW:1];
        prog_data <= ioctl_dout;
        // Even byte goes to the upper half
        prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
    end
end

endmodule

/* game_rom_top.sv */
module game_rom_top (
    input  logic                         clk,
    input  logic                         arst_n,
    // Graphics fetcher
    input  logic                         gfx_cs,
    input  logic [17:0]                  gfx_addr,
    output logic                         gfx_ok,
    output logic [15:0]                  gfx_data,
    // Sound CPU
    input  logic                         snd_cs,
    input  logic [14:0]                  snd_addr,
    output logic                         snd_ok,
    output logic [7:0]                   snd_data,
    // Main CPU
    input  logic                         main_cs,
    input  logic [17:0]                  main_addr,
    output logic                         main_ok,
    output logic [7:0]                   main_data,
    // ROM load
    input  logic                         downloading,
    input  logic [24:0]                  ioctl_addr,
    input  logic [7:0]                   ioctl_dout,
    input  logic                         ioctl_wr,
    output logic [rom_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we,
    // SDRAM
    output logic                         sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0] sdram_addr,
    input  logic                         sdram_ack,
    input  logic                         data_rdy,
    input  logic [15:0]                  data_read
);

rom_pkg::slot_req_t reqs [rom_pkg::NUM_SLOTS];
rom_pkg::slot_rsp_t rsp;

rom_slot #(.AW(18), .DW(16)) u_gfx (
    .clk     ( clk                          ),
    .arst_n  ( arst_n                       ),
    .cs      ( gfx_cs                       ),
    .addr    ( gfx_addr                     ),
    .ok      ( gfx_ok                       ),
    .data    ( gfx_data                     ),
    .my_slot ( rom_pkg::SLOT_GFX            ),
    .req     ( reqs[rom_pkg::SLOT_GFX]      ),
    .rsp     ( rsp                          )
);

rom_slot #(.AW(15), .DW(8)) u_snd (
    .clk     ( clk                          ),
    .arst_n  ( arst_n                       ),
    .cs      ( snd_cs                       ),
    .addr    ( snd_addr                     ),
    .ok      ( snd_ok                       ),
    .data    ( snd_data                     ),
    .my_slot ( rom_pkg::SLOT_SND            ),
    .req     ( reqs[rom_pkg::SLOT_SND]      ),
    .rsp     ( rsp                          )
);

rom_slot #(.AW(18), .DW(8)) u_main (
    .clk     ( clk                          ),
    .arst_n  ( arst_n                       ),
    .cs      ( main_cs                      ),
    .addr    ( main_addr                    ),
    .ok      ( main_ok                      ),
    .data    ( main_data                    ),
    .my_slot ( rom_pkg::SLOT_MAIN           ),
    .req     ( reqs[rom_pkg::SLOT_MAIN]     ),
    .rsp     ( rsp                          )
);

// Ack is shared, download and reads never overlap
rom_arbiter u_arbiter (
    .clk         ( clk          ),
    .arst_n      ( arst_n       ),
    .downloading ( downloading  ),
    .reqs        ( reqs         ),
    .rsp         ( rsp          ),
    .sdram_req   ( sdram_req    ),
    .sdram_addr  ( sdram_addr   ),
    .sdram_ack   ( sdram_ack    ),
    .data_rdy    ( data_rdy     ),
    .data_read   ( data_read    )
);

rom_dwnld u_dwnld (
    .clk         ( clk          ),
    .arst_n      ( arst_n       ),
    .downloading ( downloading  ),
    .ioctl_addr  ( ioctl_addr   ),
    .ioctl_dout  ( ioctl_dout   ),
    .ioctl_wr    ( ioctl_wr     ),
    .sdram_ack   ( sdram_ack    ),
    .prog_addr   ( prog_addr    ),
    .prog_data   ( prog_data    ),
    .prog_mask   ( prog_mask    ),    // Active low
    .prog_we     ( prog_we      )
);

endmodule

/* rom_chk.sv */
module rom_chk (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 downloading,
    input logic                 sdram_req,
    input logic [21:0]          sdram_addr,
    input logic                 sdram_ack,
    input rom_pkg::slot_rsp_t   rsp
);
timeunit 1ns;
timeprecision 1ps;

addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
    sdram_req && !sdram_ack |=> $stable(sdram_addr))
    else $error("sdram_addr moved while sdram_req waited for ack");

// Download owns the SDRAM
no_req_in_dl: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(sdram_req) |-> !$past(downloading))
    else $error("sdram_req started during a download");

fill_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    rsp.fill |=> !rsp.fill)
    else $error("fill held for more than one cycle");

endmodule

bind rom_arbiter rom_chk u_chk (
    .clk         ( clk         ),
    .arst_n      ( arst_n      ),
    .downloading ( downloading ),
    .sdram_req   ( sdram_req   ),
    .sdram_addr  ( sdram_addr  ),
    .sdram_ack   ( sdram_ack   ),
    .rsp         ( rsp         )
);

/* rom_monitor.sv */
module rom_monitor (
    input  logic        clk,
    input  logic        item_active,
    input  byte         op,
    input  logic [1:0]  slot,
    input  logic [24:0] addr,
    input  logic [7:0]  val,
    input  logic [2:0]  cs,            // main, snd, gfx
    input  logic [2:0]  ok,
    input  logic [15:0] gfx_data,
    input  logic [7:0]  snd_data,
    input  logic [7:0]  main_data,
    input  logic        downloading,
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    input  logic        prog_we,
    input  logic [21:0] prog_addr,
    input  logic [7:0]  prog_data,
    input  logic [1:0]  prog_mask,
    output int          tests,
    output int          errors
);
timeunit 1ns;
timeprecision 1ps;

logic [21:0] exp_q [$];        // Reads still to come, in grant order
logic [21:0] cached [3];
logic [2:0]  cached_ok = 3'b000;
logic [2:0]  want;             // Slots with unchecked data
logic        active_q = 1'b0;
logic        req_q = 1'b0;
logic        we_q = 1'b0;
int          we_rises;
int          err_base;
int          n_tests = 0;
int          n_errors = 0;

assign tests  = n_tests;
assign errors = n_errors;

// gfx reads words, snd and main read bytes
function automatic logic [21:0] word_of(int s);
    return (s == 0) ? addr[21:0] : {1'b0, addr[21:1]};
endfunction

function automatic logic [21:0] region(int s);
    return (s == 0) ? 22'h080000 : (s == 1) ? 22'h040000 : 22'h000000;
endfunction

function automatic logic [15:0] expect_data(int s);
    logic [15:0] w;
    w = 16'(region(s) + word_of(s)) ^ 16'h5a5a;
    if (s == 0) begin
        return w;
    end
    return addr[0] ? {8'h00, w[7:0]} : {8'h00, w[15:8]};    // Even byte in the upper half
endfunction

function automatic logic [15:0] dut_data(int s);
    return (s == 0) ? gfx_data : (s == 1) ? {8'h00, snd_data} : {8'h00, main_data};
endfunction

task automatic err_value(string name, logic [21:0] expv, logic [21:0] actv);
    $display("ERR %s expected %h actual %h", name, expv, actv);
    n_errors++;
endtask

task automatic err_text(string what);
    $display("Error: %s", what);
    n_errors++;
endtask

always @(posedge clk) begin
    logic [21:0] next_addr;
    if (item_active && !active_q) begin
        err_base = n_errors;
        we_rises = 0;
        want     = 3'b000;
        exp_q.delete();
        for (int s = 0; s < 3; s++) begin
            if (op == "P" || (op != "D" && slot == 2'(s))) begin
                want[s] = 1'b1;
                if (!(cached_ok[s] && cached[s] == word_of(s))) begin
                    exp_q.push_back(region(s) + word_of(s));
                end
            end
        end
    end
    if (sdram_req && !req_q) begin
        if (downloading) begin
            err_text("sdram_req rose while downloading");
        end
        if (exp_q.size() == 0) begin
            err_text("sdram_req rose with no cache miss outstanding");
        end else begin
            next_addr = exp_q.pop_front();
            if (sdram_addr !== next_addr) begin
                err_value("sdram_addr", next_addr, sdram_addr);
            end
        end
    end
    for (int s = 0; s < 3; s++) begin
        if (want[s] && cs[s] && ok[s]) begin
            want[s]      = 1'b0;
            cached[s]    = word_of(s);
            cached_ok[s] = 1'b1;
            if (dut_data(s) !== expect_data(s)) begin
                err_value(s == 0 ? "gfx_data" : s == 1 ? "snd_data" : "main_data",
                          22'(expect_data(s)), 22'(dut_data(s)));
            end
        end
    end
    if (prog_we && !we_q) begin
        we_rises++;
        if (prog_addr !== addr[22:1]) begin
            err_value("prog_addr", addr[22:1], prog_addr);
        end
        if (prog_data !== val) begin
            err_value("prog_data", 22'(val), 22'(prog_data));
        end
        if (prog_mask !== (addr[0] ? 2'b10 : 2'b01)) begin
            err_value("prog_mask", addr[0] ? 22'h2 : 22'h1, 22'(prog_mask));
        end
    end
    if (!item_active && active_q) begin
        if (exp_q.size() != 0) begin
            err_text("a cache miss never reached the SDRAM");
        end
        if (want != 3'b000) begin
            err_text("a read ended without returning data");
        end
        if (we_rises != ((op == "D") ? 1 : 0)) begin
            err_text("wrong number of prog_we pulses");
        end
        n_tests++;
        $display("item %0d %c addr %h %s", n_tests, op, addr,
                 (n_errors == err_base) ? "ok" : "FAILED");
    end
    active_q <= item_active;
    req_q    <= sdram_req;
    we_q     <= prog_we;
end

endmodule

/* tb_game_rom.sv */
module tb_game_rom;
timeunit 1ns;
timeprecision 1ps;

logic        clk = 1'b0;
logic        arst_n;
logic        gfx_cs, snd_cs, main_cs;
logic [17:0] gfx_addr, main_addr;
logic [14:0] snd_addr;
logic        gfx_ok, snd_ok, main_ok;
logic [15:0] gfx_data;
logic [7:0]  snd_data, main_data;
logic        downloading, ioctl_wr;
logic [24:0] ioctl_addr;
logic [7:0]  ioctl_dout;
logic [21:0] prog_addr, sdram_addr;
logic [7:0]  prog_data;
logic [1:0]  prog_mask;
logic        prog_we, sdram_req, sdram_ack, data_rdy;
logic [15:0] data_read;

// Current trace item, shared with the monitor
byte         op;
logic [1:0]  slot;
logic [24:0] addr;
logic [7:0]  val;
logic        item_active;
logic        aborted;
int          tests, errors;

always #5 clk = ~clk;

game_rom_top i_dut (.*);

rom_monitor u_monitor (.*, .cs({main_cs, snd_cs, gfx_cs}), .ok({main_ok, snd_ok, gfx_ok}));

// SDRAM model, serves reads and download writes alike
always begin
    int          wait_cyc;
    logic        is_read;
    logic [21:0] req_addr;
    @(negedge clk);
    if (sdram_req || prog_we) begin
        is_read  = sdram_req;
        req_addr = sdram_addr;
        wait_cyc = 1 + int'($urandom % 4);
        repeat (wait_cyc - 1) @(negedge clk);
        sdram_ack = 1'b1;
        @(negedge clk);
        sdram_ack = 1'b0;
        if (is_read) begin
            wait_cyc = 1 + int'($urandom % 3);    // data_rdy lag
            repeat (wait_cyc - 1) @(negedge clk);
            data_read = req_addr[15:0] ^ 16'h5a5a;
            data_rdy  = 1'b1;
            @(negedge clk);
            data_rdy = 1'b0;
        end
    end
end

// Other slots see the address too but their cs stays low
task automatic drive_slots(input logic [2:0] sel, input logic [24:0] a);
    {main_cs, snd_cs, gfx_cs} = sel;
    gfx_addr  = a[17:0];
    snd_addr  = a[14:0];
    main_addr = a[17:0];
endtask

task automatic wait_ok(input logic [2:0] mask);
    int n;
    for (n = 0; n < 200; n++) begin
        @(posedge clk);
        if (({main_ok, snd_ok, gfx_ok} & mask) == mask) begin
            break;
        end
    end
    if (n == 200) begin
        $display("Timeout: slots %b never gave ok within 200 cycles", mask);
        aborted = 1'b1;
    end
    @(negedge clk);
endtask

task automatic load_byte();
    int n;
    downloading = 1'b1;
    ioctl_addr  = addr;
    ioctl_dout  = val;
    ioctl_wr    = 1'b1;
    @(negedge clk);
    ioctl_wr = 1'b0;
    for (n = 0; n < 200; n++) begin
        @(posedge clk);
        if (!prog_we) begin
            break;
        end
    end
    if (n == 200) begin
        $display("Timeout: prog_we was never acknowledged");
        aborted = 1'b1;
    end
    @(negedge clk);
endtask

initial begin
    int    fd;
    string line;
    void'($urandom(32'hb2ef9d06));
    arst_n      = 1'b0;
    downloading = 1'b0;
    ioctl_wr    = 1'b0;
    ioctl_addr  = '0;
    ioctl_dout  = '0;
    sdram_ack   = 1'b0;
    data_rdy    = 1'b0;
    data_read   = '0;
    item_active = 1'b0;
    aborted     = 1'b0;
    drive_slots(3'b000, '0);
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    fd = $fopen("rom_trace.txt", "r");
    if (fd == 0) begin
        $display("Cannot open rom_trace.txt");
        aborted = 1'b1;
    end
    while (!aborted && $fgets(line, fd) > 0) begin
        if (line.len() < 3 || line.getc(0) == "#") begin
            continue;
        end
        void'($sscanf(line, "%c %d %h %h", op, slot, addr, val));
        item_active = 1'b1;
        case (op)
            "D": load_byte();
            "P": begin
                downloading = 1'b0;
                drive_slots(3'b111, addr);
                wait_ok(3'b111);
            end
            "H": begin
                downloading = 1'b1;
                drive_slots(3'b001 << slot, addr);
                repeat (20) @(negedge clk);    // Miss has to stay parked
                downloading = 1'b0;
                wait_ok(3'b001 << slot);
            end
            default: begin
                downloading = 1'b0;
                drive_slots(3'b001 << slot, addr);
                wait_ok(3'b001 << slot);
            end
        endcase
        drive_slots(3'b000, addr);
        item_active = 1'b0;
        @(negedge clk);
    end
    repeat (2) @(negedge clk);
    $display("%0d items, %0d errors", tests, errors);
    if (errors == 0 && !aborted) begin
        $display("test passed");
    end else begin
        $display("test failed");
    end
    $finish;
end

endmodule

/* rom_trace.txt */
# Columns: op slot addr byte, addr and byte in hex, slot 0 gfx 1 snd 2 main
# R read, P read on all slots at once, H read held behind a download, D download byte
D 0 0000000 12
D 0 0000001 34
D 0 0080102 56
D 0 1fffffb 78
H 1 0000123 00
R 0 0000010 00
R 0 0000010 00
R 1 0000020 00
R 1 0000021 00
R 2 0000101 00
R 2 0000100 00
R 2 003ffff 00
R 0 003fffe 00
P 0 0000200 00
R 1 0000201 00
R 2 0000200 00
P 0 0000200 00
P 0 0004000 00
D 0 0100005 9a
H 2 0000555 00
R 0 0000000 00

/* compile.f */
rom_pkg.sv
rom_slot.sv
rom_arbiter.sv
rom_dwnld.sv
game_rom_top.sv
rom_chk.sv
rom_monitor.sv
tb_game_rom.sv

/* Makefile */
TOP := tb_game_rom

.PHONY: all lint clean

all:
	verilator --binary --assert --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
